// File: rtl/apb_requester.sv
`timescale 1ns/1ns

module apb_requester import fmc_apb_pkg::*; (
	input  logic apb,
	input  logic preset_n,
	input  apb_req_t req,
	input  logic start,
	input  apb_in_t apb_i,
	output apb_out_t apb_o,
	output logic busy,
	output logic [apb_data_w-1:0] rdata
);

	apb_phase_t phase;

	// Request held stable from setup to completion
	apb_req_t req_q;

	logic accept;
	logic done;

	// Start is only taken while idle
	assign accept = (phase == ph_idle) && start;
	// Access phase ends on pready
	assign done = (phase == ph_access) && apb_i.pready;

	always_ff @(posedge apb or negedge preset_n) begin
		if (!preset_n) begin
			phase <= ph_idle;
		end else begin
			case (phase)
				ph_idle: begin
					if (start) begin
						phase <= ph_setup;
					end
				end
				ph_setup: phase <= ph_access;
				ph_access: begin
					// Wait states while the completer holds pready low
					if (apb_i.pready) begin
						phase <= ph_idle;
					end
				end
				default: phase <= ph_idle;
			endcase
		end
	end

	always_ff @(posedge apb) begin
		if (accept) begin
			req_q <= req;
		end
		// Read data kept for the sequencer to return in halves
		if (done && !req_q.write) begin
			rdata <= apb_i.prdata;
		end
	end

	assign busy = (phase != ph_idle);

	assign apb_o = '{
		psel: busy,
		penable: (phase == ph_access),
		pwrite: req_q.write,
		paddr: req_q.addr,
		pwdata: req_q.wdata,
		pstrb: req_q.strb
	};

endmodule

// File: rtl/apb_reset_hold.sv
`timescale 1ns/1ns

module apb_reset_hold import fmc_apb_pkg::*; (
	input  logic apb,
	input  logic pll_lock,
	output logic preset_n
);

	// Clocks seen since lock came up
	logic [hold_w-1:0] hold_cnt;

	always_ff @(posedge apb or negedge pll_lock) begin
		if (!pll_lock) begin
			// Loss of lock pulls the APB side into reset at once
			hold_cnt <= '0;
			preset_n <= 1'b0;
		end else if (!preset_n) begin
			hold_cnt <= hold_cnt + 1'b1;
			// Release on the last edge of the hold, counter then freezes
			if (hold_cnt == hold_w'(reset_hold_cycles - 1)) begin
				preset_n <= 1'b1;
			end
		end
	end

endmodule

// File: rtl/fmc_activity_counters.sv
`timescale 1ns/1ns

module fmc_activity_counters import fmc_apb_pkg::*; (
	input  logic apb,
	input  logic preset_n,
	input  apb_out_t apb_o,
	input  apb_in_t apb_i,
	input  logic fmc_cs_n,
	output activity_t activity,
	output logic activity_update
);

	// Position inside the current interval
	logic [interval_w-1:0] ivl_cnt;
	logic interval_end;

	// Running counts for the current interval
	logic [count_w-1:0] rd_cnt;
	logic [count_w-1:0] wr_cnt;
	logic [count_w-1:0] sel_cnt;

	// Per-cycle events
	logic apb_done;
	logic rd_evt;
	logic wr_evt;

	assign apb_done = apb_o.psel && apb_o.penable && apb_i.pready;
	assign rd_evt = apb_done && !apb_o.pwrite;
	assign wr_evt = apb_done && apb_o.pwrite;
	assign interval_end = (ivl_cnt == interval_w'(count_interval_cycles - 1));

	always_ff @(posedge apb or negedge preset_n) begin
		if (!preset_n) begin
			ivl_cnt <= '0;
			rd_cnt <= '0;
			wr_cnt <= '0;
			sel_cnt <= '0;
			activity <= '0;
			activity_update <= 1'b0;
		end else begin
			ivl_cnt <= ivl_cnt + 1'b1;
			activity_update <= interval_end;
			if (interval_end) begin
				// Publish including the last cycle, then start over
				ivl_cnt <= '0;
				activity.apb_reads <= rd_cnt + count_w'(rd_evt);
				activity.apb_writes <= wr_cnt + count_w'(wr_evt);
				activity.fmc_select_cycles <= sel_cnt + count_w'(!fmc_cs_n);
				rd_cnt <= '0;
				wr_cnt <= '0;
				sel_cnt <= '0;
			end else begin
				rd_cnt <= rd_cnt + count_w'(rd_evt);
				wr_cnt <= wr_cnt + count_w'(wr_evt);
				sel_cnt <= sel_cnt + count_w'(!fmc_cs_n);
			end
		end
	end

endmodule

// File: rtl/fmc_apb_bridge.sv
`timescale 1ns/1ns

module fmc_apb_bridge import fmc_apb_pkg::*; (
	input  logic apb,
	input  logic pll_lock,
	input  fmc_pins_t fmc,
	output logic [fmc_data_w-1:0] fmc_ad_out,
	output logic fmc_ad_oe,
	output logic fmc_nwait,
	output apb_out_t apb_o,
	input  apb_in_t apb_i,
	output logic preset_n,
	output activity_t activity,
	output logic activity_update
);

	// Sequencer to requester
	apb_req_t req;
	logic start;
	logic busy;
	logic [apb_data_w-1:0] rdata;

	// MCU drives the bus unless it is reading
	assign fmc_ad_oe = !fmc.noe;

	////////////////////////////////////////////////////////////
	// Reset after lock

	apb_reset_hold reset_hold_i (
		.apb(apb),
		.pll_lock(pll_lock),
		.preset_n(preset_n)
	);

	////////////////////////////////////////////////////////////
	// FMC side and APB side

	fmc_bus_sequencer sequencer_i (
		.apb(apb),
		.preset_n(preset_n),
		.fmc(fmc),
		.busy(busy),
		.rdata(rdata),
		.req(req),
		.start(start),
		.fmc_ad_out(fmc_ad_out),
		.fmc_nwait(fmc_nwait)
	);

	apb_requester requester_i (
		.apb(apb),
		.preset_n(preset_n),
		.req(req),
		.start(start),
		.apb_i(apb_i),
		.apb_o(apb_o),
		.busy(busy),
		.rdata(rdata)
	);

	// Activity statistics
	fmc_activity_counters counters_i (
		.apb(apb),
		.preset_n(preset_n),
		.apb_o(apb_o),
		.apb_i(apb_i),
		.fmc_cs_n(fmc.cs_n),
		.activity(activity),
		.activity_update(activity_update)
	);

endmodule

// File: rtl/fmc_apb_pkg.sv
package fmc_apb_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths

	// Multiplexed address/data bus of the MCU
	localparam int fmc_data_w = 16;
	// Upper address pins of the FMC bank
	localparam int fmc_ahi_w = 3;
	// Byte address seen by the APB side
	localparam int byte_addr_w = 19;
	localparam int apb_data_w = 32;
	localparam int apb_addr_w = 32;
	// One strobe per APB byte lane
	localparam int apb_strb_w = apb_data_w / 8;

	////////////////////////////////////////////////////////////
	// Reset hold and activity counting

	localparam int reset_hold_cycles = 15;
	localparam int hold_w = $clog2(reset_hold_cycles);
	localparam int count_interval_cycles = 256;
	localparam int interval_w = $clog2(count_interval_cycles);
	localparam int count_w = 16;

	// FMC sequencer states
	typedef enum logic [2:0] {
		st_addr,
		st_wait,
		st_wait2,
		st_wdata_lo,
		st_wdata_hi,
		st_rdata_lo,
		st_rdata_hi,
		st_rd_end
	} fmc_state_t;

	// APB requester phases
	typedef enum logic [1:0] {
		ph_idle,
		ph_setup,
		ph_access
	} apb_phase_t;

	// FMC pins driven by the MCU
	typedef struct packed {
		logic cs_n;
		logic nl_nadv;
		logic nwe;
		logic noe;
		logic [1:0] nbl;
		logic [fmc_ahi_w-1:0] a_hi;
		logic [fmc_data_w-1:0] ad_in;
	} fmc_pins_t;

	// One APB request from the sequencer
	typedef struct packed {
		logic [apb_addr_w-1:0] addr;
		logic write;
		logic [apb_data_w-1:0] wdata;
		logic [apb_strb_w-1:0] strb;
	} apb_req_t;

	// Requester drive onto APB
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [apb_addr_w-1:0] paddr;
		logic [apb_data_w-1:0] pwdata;
		logic [apb_strb_w-1:0] pstrb;
	} apb_out_t;

	// Completer response
	typedef struct packed {
		logic pready;
		logic [apb_data_w-1:0] prdata;
	} apb_in_t;

	// Counts published once per interval
	typedef struct packed {
		logic [count_w-1:0] apb_reads;
		logic [count_w-1:0] apb_writes;
		logic [count_w-1:0] fmc_select_cycles;
	} activity_t;

endpackage

// File: rtl/fmc_bus_sequencer.sv
`timescale 1ns/1ns

module fmc_bus_sequencer import fmc_apb_pkg::*; (
	input  logic apb,
	input  logic preset_n,
	input  fmc_pins_t fmc,
	input  logic busy,
	input  logic [apb_data_w-1:0] rdata,
	output apb_req_t req,
	output logic start,
	output logic [fmc_data_w-1:0] fmc_ad_out,
	output logic fmc_nwait
);

	fmc_state_t state;

	// Request being assembled from the FMC side
	logic [byte_addr_w-1:0] addr_q;
	logic write_q;
	logic [apb_data_w-1:0] wdata_q;
	logic [apb_strb_w-1:0] strb_q;

	// Decoded bus events
	logic addr_cycle;
	logic take_lo;
	logic take_hi;
	logic read_done;

	////////////////////////////////////////////////////////////
	// Event decode

	// Address phase of a new transaction
	assign addr_cycle = (state == st_addr) && !fmc.cs_n && !fmc.nl_nadv;

	// Low half is taken in the first cycle nwait is seen high.
	// nwait is a registered copy of busy, so this trails the fall
	// of busy by one clock, the round trip of the wait pin
	assign take_lo = (state == st_wdata_lo) && !fmc.cs_n && fmc_nwait;
	assign take_hi = (state == st_wdata_hi) && !fmc.cs_n;

	// Read finished once busy is low with no start still in flight
	assign read_done = (state == st_wait2) && !busy && !start;

	////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge apb or negedge preset_n) begin
		if (!preset_n) begin
			state <= st_addr;
			start <= 1'b0;
			fmc_nwait <= 1'b1;
		end else begin
			start <= 1'b0;
			fmc_nwait <= 1'b1;
			if (fmc.cs_n) begin
				// Deselect ends any transaction
				state <= st_addr;
			end else begin
				// Stall the host while a posted write is still on APB
				fmc_nwait <= !busy;
				case (state)
					st_addr: begin
						if (!fmc.nl_nadv) begin
							if (fmc.nwe) begin
								// Reads wait from the very next cycle
								state <= st_wait;
								fmc_nwait <= 1'b0;
							end else begin
								state <= st_wdata_lo;
							end
						end
					end
					st_wait: begin
						fmc_nwait <= 1'b0;
						// Dispatch the read once the APB side is free
						if (!busy && !start) begin
							start <= 1'b1;
							state <= st_wait2;
						end
					end
					st_wait2: begin
						// Hold off until the read data is latched
						fmc_nwait <= read_done;
						if (read_done) begin
							state <= st_rdata_lo;
						end
					end
					st_wdata_lo: begin
						if (take_lo) begin
							state <= st_wdata_hi;
						end
					end
					st_wdata_hi: begin
						// Posted, the host may leave right away
						start <= 1'b1;
						state <= st_addr;
					end
					st_rdata_lo: state <= st_rdata_hi;
					st_rdata_hi: state <= st_rd_end;
					st_rd_end: begin
						// Dummy clocks after a read are ignored until deselect
						state <= st_rd_end;
					end
					default: state <= st_addr;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Request payload

	always_ff @(posedge apb) begin
		if (addr_cycle) begin
			// Bus carries a 16-bit word address, top upper pin is
			// beyond the decoded window
			addr_q <= {fmc.a_hi[fmc_ahi_w-2:0], fmc.ad_in, 1'b0};
			write_q <= !fmc.nwe;
			// Reads go out with no lanes enabled
			strb_q <= '0;
		end
		if (take_lo) begin
			wdata_q[fmc_data_w-1:0] <= fmc.ad_in;
			strb_q[1:0] <= ~fmc.nbl;
		end
		if (take_hi) begin
			wdata_q[apb_data_w-1:fmc_data_w] <= fmc.ad_in;
			strb_q[3:2] <= ~fmc.nbl;
		end
	end

	assign req = '{
		addr: apb_addr_w'(addr_q),
		write: write_q,
		wdata: wdata_q,
		strb: strb_q
	};

	// Read data back to the host, low half first
	always_comb begin
		case (state)
			st_rdata_lo: fmc_ad_out = rdata[fmc_data_w-1:0];
			st_rdata_hi: fmc_ad_out = rdata[apb_data_w-1:fmc_data_w];
			default: fmc_ad_out = '0;
		endcase
	end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module tb_fmc_apb_bridge
out=$(./obj_dir/Vtb_fmc_apb_bridge)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "No errors"; then
	exit 0
else
	exit 1
fi

// File: sources.f
rtl/fmc_apb_pkg.sv
rtl/apb_reset_hold.sv
rtl/fmc_bus_sequencer.sv
rtl/apb_requester.sv
rtl/fmc_activity_counters.sv
rtl/fmc_apb_bridge.sv
tb/bridge_checker.sv
tb/tb_fmc_apb_bridge.sv

// File: tb/bridge_checker.sv
`timescale 1ns/1ns

module bridge_checker import fmc_apb_pkg::*; (
	input  logic apb,
	input  logic pll_lock,
	input  logic preset_n,
	input  fmc_pins_t fmc,
	input  logic [fmc_data_w-1:0] fmc_ad_out,
	input  logic fmc_ad_oe,
	input  logic fmc_nwait,
	input  apb_out_t apb_o,
	input  apb_in_t apb_i,
	input  activity_t activity,
	input  logic activity_update,
	input  logic test_go,
	input  logic [127:0] test_name,
	input  logic test_write,
	input  logic [31:0] test_addr,
	input  logic [31:0] test_data,
	input  logic [3:0] test_nbl,
	output int value_errs,
	output int proto_errs,
	output int pending
);

	// Expected APB transfers in FMC order
	logic [127:0] q_name[$];
	logic q_write[$];
	logic [31:0] q_addr[$];
	logic [31:0] q_data[$];
	logic [3:0] q_nbl[$];

	// Transaction now on the FMC side
	logic [127:0] cur_name = '0;
	logic cur_write = 1'b0;
	logic [31:0] cur_data = '0;
	logic rd_half = 1'b0;
	logic rd_open = 1'b0;

	// Transfer now in its setup phase
	logic [127:0] e_name;
	logic e_write;
	logic [31:0] e_addr;
	logic [31:0] e_data;
	logic [3:0] e_nbl;

	// Previous cycle of the watched ports
	apb_out_t o_q = '0;
	logic pready_q = 1'b0;
	logic nwait_q = 1'b1;

	int lock_edges = 0;
	logic released = 1'b0;
	int acc_rd = 0;
	int acc_wr = 0;
	int acc_sel = 0;
	int acc_cyc = 0;
	int n_val = 0;
	int n_proto = 0;

	assign value_errs = n_val;
	assign proto_errs = n_proto;

	task automatic check_val(input logic [127:0] name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Fail %0s %0s expected %h actual %h", name, what, exp, act);
			n_val++;
		end
	endtask

	task automatic breach(input string msg);
		$display("Protocol error at %0t ns: %0s", $time, msg);
		n_proto++;
	endtask

	// Rising edges seen with lock up and the APB side still in reset
	always @(posedge apb) begin
		if (pll_lock && !preset_n) begin
			lock_edges <= lock_edges + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// Sampled at the falling edge away from the DUT updates

	always @(negedge apb) begin
		if (!preset_n) begin
			if (apb_o.psel || apb_o.penable || !fmc_nwait || activity_update || fmc_ad_oe) begin
				breach("outputs active while preset_n is low");
			end
		end else begin
			if (!released) begin
				released = 1'b1;
				check_val(128'("reset_hold"), "edges", reset_hold_cycles, 32'(lock_edges));
			end
			// New FMC transaction from the host
			if (test_go) begin
				q_name.push_back(test_name);
				q_write.push_back(test_write);
				q_addr.push_back(test_addr);
				q_data.push_back(test_data);
				q_nbl.push_back(test_nbl);
				cur_name = test_name;
				cur_write = test_write;
				cur_data = test_data;
				rd_half = 1'b0;
				rd_open = !test_write;
			end
			// Read halves follow the rise of nwait
			if (!cur_write && !fmc.cs_n && fmc.nwe && !fmc.noe) begin
				if (!fmc_ad_oe) begin
					breach("fmc_ad_oe low while the host reads");
				end
				if (rd_half) begin
					check_val(cur_name, "rdata_hi", 32'(cur_data[31:16]), 32'(fmc_ad_out));
					rd_half = 1'b0;
					rd_open = 1'b0;
				end else if (fmc_nwait && !nwait_q) begin
					check_val(cur_name, "rdata_lo", 32'(cur_data[15:0]), 32'(fmc_ad_out));
					rd_half = 1'b1;
				end
			end
			// Host left before both read halves came back
			if (rd_open && fmc.cs_n) begin
				breach("read ended before both data halves were returned");
				rd_open = 1'b0;
			end

			////////////////////////////////////////////////////////////
			// APB handshake

			if (apb_o.penable && !apb_o.psel) begin
				breach("penable high without psel");
			end
			if (apb_o.psel && !o_q.psel && apb_o.penable) begin
				breach("psel rose together with penable");
			end
			if (o_q.psel && !o_q.penable && !(apb_o.psel && apb_o.penable)) begin
				breach("no access phase after setup");
			end
			if (o_q.psel && o_q.penable && !pready_q) begin
				if (!apb_o.psel || !apb_o.penable || apb_o.paddr != o_q.paddr
					|| apb_o.pwrite != o_q.pwrite || apb_o.pwdata != o_q.pwdata
					|| apb_o.pstrb != o_q.pstrb) begin
					breach("transfer dropped or changed before pready");
				end
			end
			if (o_q.psel && o_q.penable && pready_q && (apb_o.psel || apb_o.penable)) begin
				breach("psel or penable still high after completion");
			end
			// Setup phase carries the next expected transfer
			if (apb_o.psel && !apb_o.penable) begin
				if (q_addr.size() == 0) begin
					breach("APB transfer without an FMC transaction");
				end else begin
					e_name = q_name.pop_front();
					e_write = q_write.pop_front();
					e_addr = q_addr.pop_front();
					e_data = q_data.pop_front();
					e_nbl = q_nbl.pop_front();
					check_val(e_name, "paddr", {13'b0, e_addr[18:1], 1'b0}, apb_o.paddr);
					check_val(e_name, "pwrite", 32'(e_write), 32'(apb_o.pwrite));
					if (e_write) begin
						check_val(e_name, "pwdata", e_data, apb_o.pwdata);
						check_val(e_name, "pstrb", {28'b0, ~e_nbl}, 32'(apb_o.pstrb));
					end
				end
			end

			////////////////////////////////////////////////////////////
			// Activity counts over the last interval

			if (activity_update) begin
				check_val(128'("activity"), "interval_cycles", count_interval_cycles,
					32'(acc_cyc));
				check_val(128'("activity"), "apb_reads", 32'(acc_rd), 32'(activity.apb_reads));
				check_val(128'("activity"), "apb_writes", 32'(acc_wr), 32'(activity.apb_writes));
				check_val(128'("activity"), "fmc_select_cycles", 32'(acc_sel),
					32'(activity.fmc_select_cycles));
				acc_rd = 0;
				acc_wr = 0;
				acc_sel = 0;
				acc_cyc = 0;
			end
			if (apb_o.psel && apb_o.penable && apb_i.pready) begin
				if (apb_o.pwrite) begin
					acc_wr++;
				end else begin
					acc_rd++;
				end
			end
			if (!fmc.cs_n) begin
				acc_sel++;
			end
			acc_cyc++;
		end
		o_q = apb_o;
		pready_q = apb_i.pready;
		nwait_q = fmc_nwait;
		pending = q_addr.size();
	end

endmodule

// File: tb/bridge_tests.txt
# Columns: name, op (W or R), byte address (hex), data (hex),
# nbl as active-low byte lanes (hex, bit 0 is lane 0), completer wait cycles (decimal)
wr_basic W 00010 12345678 0 0
rd_basic R 00010 cafe0001 0 0
wr_lanes W 00024 a5a55a5a 5 2
rd_wait3 R 00024 0badf00d 0 3
wr_odd W 3ff41 deadbeef a 1
wr_stall W 40000 11112222 0 7
rd_after R 40004 33334444 0 7
wr_pair1 W 7fffc 55aa55aa 3 6
wr_pair2 W 00100 01020304 c 5
rd_top R 7fffe 89abcdef 0 0
wr_zero W 00000 ffffffff f 4
rd_last R 00200 13579bdf 0 1

// File: tb/tb_fmc_apb_bridge.sv
`timescale 1ns/1ns

module tb_fmc_apb_bridge import fmc_apb_pkg::*; ();

	logic apb = 1'b0;
	logic pll_lock;
	fmc_pins_t fmc;
	logic [fmc_data_w-1:0] fmc_ad_out;
	logic fmc_ad_oe;
	logic fmc_nwait;
	apb_out_t apb_o;
	apb_in_t apb_i = '0;
	logic preset_n;
	activity_t activity;
	logic activity_update;

	// Test table from the data file
	logic [127:0] t_name[64];
	logic [7:0] t_op[64];
	logic [31:0] t_addr[64];
	logic [31:0] t_data[64];
	logic [3:0] t_nbl[64];
	int t_wait[64];
	int n_tests = 0;
	int max_wait = 0;
	logic loaded = 1'b0;

	// Current test as seen by the checker
	logic test_go;
	logic [127:0] test_name;
	logic test_write;
	logic [31:0] test_addr;
	logic [31:0] test_data;
	logic [3:0] test_nbl;

	// Completer responses in FMC transaction order
	int cq_wait[$];
	logic [31:0] cq_data[$];
	int wait_left = 0;

	int seed;
	int gap;
	int value_errs;
	int proto_errs;
	int pending;
	int other_errs = 0;
	longint limit_ns;

	always #10 apb = ~apb;

	fmc_apb_bridge fmc_apb_bridge_i (
		.apb(apb),
		.pll_lock(pll_lock),
		.fmc(fmc),
		.fmc_ad_out(fmc_ad_out),
		.fmc_ad_oe(fmc_ad_oe),
		.fmc_nwait(fmc_nwait),
		.apb_o(apb_o),
		.apb_i(apb_i),
		.preset_n(preset_n),
		.activity(activity),
		.activity_update(activity_update)
	);

	bridge_checker checker_i (
		.apb(apb),
		.pll_lock(pll_lock),
		.preset_n(preset_n),
		.fmc(fmc),
		.fmc_ad_out(fmc_ad_out),
		.fmc_ad_oe(fmc_ad_oe),
		.fmc_nwait(fmc_nwait),
		.apb_o(apb_o),
		.apb_i(apb_i),
		.activity(activity),
		.activity_update(activity_update),
		.test_go(test_go),
		.test_name(test_name),
		.test_write(test_write),
		.test_addr(test_addr),
		.test_data(test_data),
		.test_nbl(test_nbl),
		.value_errs(value_errs),
		.proto_errs(proto_errs),
		.pending(pending)
	);

	////////////////////////////////////////////////////////////
	// Test file and host driver

	task automatic load_tests();
		int fd;
		int n;
		string line;
		fd = $fopen("tb/bridge_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the tests file");
			other_errs++;
		end else begin
			while (!$feof(fd) && n_tests < 64) begin
				line = "";
				n = $fgets(line, fd);
				// Skip blank and comment lines
				if (n > 1 && line[0] != "#") begin
					n = $sscanf(line, "%s %s %h %h %h %d", t_name[n_tests], t_op[n_tests],
						t_addr[n_tests], t_data[n_tests], t_nbl[n_tests], t_wait[n_tests]);
					if (n == 6) begin
						if (t_wait[n_tests] > max_wait) begin
							max_wait = t_wait[n_tests];
						end
						n_tests++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Address cycle that also hands the test to the checker and completer
	task automatic addr_cycle(input int i, input logic write);
		@(posedge apb);
		test_go <= 1'b1;
		test_name <= t_name[i];
		test_write <= write;
		test_addr <= t_addr[i];
		test_data <= t_data[i];
		test_nbl <= t_nbl[i];
		cq_wait.push_back(t_wait[i]);
		cq_data.push_back(t_data[i]);
		fmc.cs_n <= 1'b0;
		fmc.nl_nadv <= 1'b0;
		fmc.nwe <= !write;
		fmc.noe <= 1'b1;
		fmc.a_hi <= {1'b0, t_addr[i][18:17]};
		fmc.ad_in <= t_addr[i][16:1];
	endtask

	task automatic wait_nwait();
		@(negedge apb);
		while (!fmc_nwait) begin
			@(negedge apb);
		end
	endtask

	task automatic release_bus();
		fmc.cs_n <= 1'b1;
		fmc.nl_nadv <= 1'b1;
		fmc.nwe <= 1'b1;
		fmc.noe <= 1'b1;
		fmc.nbl <= 2'b00;
	endtask

	task automatic host_write(input int i);
		addr_cycle(i, 1'b1);
		@(posedge apb);
		test_go <= 1'b0;
		fmc.nl_nadv <= 1'b1;
		fmc.ad_in <= t_data[i][15:0];
		fmc.nbl <= t_nbl[i][1:0];
		// Low half is held while nwait is low
		wait_nwait();
		@(posedge apb);
		fmc.ad_in <= t_data[i][31:16];
		fmc.nbl <= t_nbl[i][3:2];
		@(posedge apb);
		release_bus();
	endtask

	task automatic host_read(input int i);
		addr_cycle(i, 1'b0);
		@(posedge apb);
		test_go <= 1'b0;
		fmc.nl_nadv <= 1'b1;
		fmc.noe <= 1'b0;
		// Low half then high half one cycle later
		wait_nwait();
		@(negedge apb);
		@(posedge apb);
		release_bus();
	endtask

	////////////////////////////////////////////////////////////
	// APB completer

	always @(posedge apb) begin
		if (apb_o.psel && !apb_o.penable) begin
			if (cq_wait.size() > 0) begin
				wait_left <= cq_wait[0];
				apb_i.pready <= (cq_wait[0] == 0);
				apb_i.prdata <= cq_data[0];
				void'(cq_wait.pop_front());
				void'(cq_data.pop_front());
			end else begin
				apb_i.pready <= 1'b1;
				apb_i.prdata <= '0;
			end
		end else if (apb_o.psel && apb_o.penable) begin
			if (apb_i.pready) begin
				apb_i.pready <= 1'b0;
			end else begin
				wait_left <= wait_left - 1;
				apb_i.pready <= (wait_left == 1);
			end
		end
	end

	// Watchdog scaled by the test count and longest stall
	initial begin
		wait (loaded);
		limit_ns = (longint'(n_tests) * (40 + max_wait) + 2 * count_interval_cycles) * 20;
		#(limit_ns);
		$display("Timeout: the run did not finish within %0d ns", limit_ns);
		$display("Errors found");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		seed = 35;
		pll_lock = 1'b0;
		fmc = '{cs_n: 1'b1, nl_nadv: 1'b1, nwe: 1'b1, noe: 1'b1, nbl: 2'b00,
			a_hi: '0, ad_in: '0};
		test_go = 1'b0;
		test_name = '0;
		test_write = 1'b0;
		test_addr = '0;
		test_data = '0;
		test_nbl = '0;
		load_tests();
		loaded = 1'b1;
		repeat (3) @(posedge apb);
		pll_lock <= 1'b1;
		wait (preset_n);
		for (int i = 0; i < n_tests; i++) begin
			if (t_op[i] == "W") begin
				host_write(i);
			end else begin
				host_read(i);
			end
			// Idle gap of 0 to 3 cycles
			gap = int'($unsigned($random(seed)) % 4);
			repeat (gap) @(posedge apb);
		end
		// Let the last posted write finish and two intervals close
		@(negedge apb);
		while (apb_o.psel) begin
			@(negedge apb);
		end
		repeat (2) @(posedge activity_update);
		// Checker finishes its last falling-edge sample first
		@(negedge apb);
		@(posedge apb);
		if (pending != 0) begin
			$display("%0d expected APB transfers never appeared", pending);
			other_errs++;
		end
		$display("Error counts: %0d value, %0d protocol, %0d other",
			value_errs, proto_errs, other_errs);
		if (value_errs + proto_errs + other_errs == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
